/* verilog/klFe_consts.svh */
// Shared timing and character constants for the front end, included by RTL and testbench
`ifndef KLFE_CONSTS_SVH
`define KLFE_CONSTS_SVH

////////////////////////////////////////
// Diagnostic bus strobe timing in clocks
////////////////////////////////////////

// Write strobe width
`define KLFE_WRITE_STROBE 3
// Write data drive width, one past the strobe
`define KLFE_WRITE_DRIVE 4
// Plain function strobe width
`define KLFE_FUNC_STROBE 17
// Read strobe width
`define KLFE_READ_STROBE 3
// Read data sampled this many clocks after the strobe rises
`define KLFE_READ_SAMPLE 2

////////////////////////////////////////
// Load file characters
////////////////////////////////////////

// Low six bits carry the data of an ASCIIized character
`define KLFE_FIELD_MASK 6'o77
`define KLFE_CHAR_COMMA 7'h2C
`define KLFE_CHAR_NEWLINE 7'h0A
// Zero count of 0 means a full 64K
`define KLFE_ZERO_MAX 17'd65536

`endif

/* verilog/klFePkg.sv */
// Shared word, address and code types, imported by the front end modules and testbench
package klFePkg;

  ////////////////////////////////////////
  // Data words and addresses
  ////////////////////////////////////////

  // PDP-10 data word
  typedef logic [35:0] tW36;
  // PDP-11 word, one load file field
  typedef logic [15:0] tW16;
  // PDP-10 physical address
  typedef logic [17:0] tMemAddr;

  ////////////////////////////////////////
  // Diagnostic bus
  ////////////////////////////////////////

  // Named diagnostic function codes, octal as in the KL10 docs
  typedef enum logic [6:0] {
    dfStopClock   = 7'o000,
    dfStartClock  = 7'o001,
    dfStepClock   = 7'o002,
    dfSetReset    = 7'o006,
    dfClrReset    = 7'o007,
    dfClrRun      = 7'o010,
    dfContinue    = 7'o012,
    dfParRegReset = 7'o046,
    dfLoadAr      = 7'o077
  } tDiagFunc;

  // Command kinds the bus master can run
  typedef enum logic [1:0] {
    dkWrite,
    dkFunc,
    dkRead
  } tDiagKind;

  ////////////////////////////////////////
  // Load file records
  ////////////////////////////////////////

  // Record letter of a load line
  // Z zeroes core, T loads words or gives the start address
  typedef enum logic [1:0] {
    rkZero,
    rkText,
    rkOther
  } tRecKind;

endpackage

/* verilog/loadLineIf.sv */
// Decoded load line fields passed from the character decoder to the word assembler
interface loadLineIf;
  import klFePkg::*;

  // Record letter of the current line, stable until the next letter
  tRecKind recKind;
  // One clock per field, checksum field included
  logic fieldStrobe;
  // Field value, valid with the strobe
  tW16 fieldWord;
  // Field number in the line, 0 is the word count
  logic [7:0] fieldIndex;
  // One clock after the checksum field strobe
  logic lineEnd;

  // Character side drives everything
  modport decoder (
    output recKind, fieldStrobe, fieldWord, fieldIndex, lineEnd
  );

  // Assembler only listens
  modport assembler (
    input recKind, fieldStrobe, fieldWord, fieldIndex, lineEnd
  );

endinterface

/* verilog/strobeTimer.sv */
// Loadable down-counter that signals the end of a diagnostic strobe window
module strobeTimer (
  input  logic       clk,
  input  logic       arstN,
  input  logic       timerLoad,
  input  logic [3:0] timerValue,
  output logic       timerDone
);

  // Count wraps below zero to expire, then parks
  localparam logic [4:0] cntExpired = 5'h1F;
  localparam logic [4:0] cntParked  = 5'h1E;

  logic [4:0] count;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count <= cntParked;
    end else if (timerLoad) begin
      count <= {1'b0, timerValue};
    end else if (count != cntParked) begin
      count <= count - 5'd1;
    end
  end

  // Single clock pulse, expiry code is passed once
  assign timerDone = count == cntExpired;

endmodule

/* verilog/diagSequencer.sv */
// Diagnostic bus master that runs one write, function or read command with fixed strobe timing
`include "klFe_consts.svh"

module diagSequencer (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cmdValid,
  input  klFePkg::tDiagKind cmdKind,
  input  klFePkg::tDiagFunc cmdFunc,
  input  klFePkg::tW36      cmdData,
  input  klFePkg::tW36      ebusDataIn,
  input  logic              timerDone,
  output logic              timerLoad,
  output logic [3:0]        timerValue,
  output klFePkg::tDiagFunc ds,
  output logic              diagStrobe,
  output klFePkg::tW36      ebusDataOut,
  output logic              driving,
  output logic              busy,
  output logic              readValid,
  output klFePkg::tW36      readData
);
  import klFePkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stStrobe,
    stTail,
    stDone
  } tSeqState;

  tSeqState state;
  tDiagKind kindQ;
  tDiagFunc funcQ;
  tW36      dataQ;
  logic     launch;
  logic     accept;

  always_comb begin
    // Only one command in flight so extra requests are dropped
    accept = cmdValid && state == stIdle && !launch;
    timerLoad = launch;
    // Timer expires one clock before the window closes
    case (kindQ)
      dkWrite: timerValue = 4'(`KLFE_WRITE_STROBE - 2);
      dkRead:  timerValue = 4'(`KLFE_READ_SAMPLE - 2);
      default: timerValue = 4'(`KLFE_FUNC_STROBE - 2);
    endcase
  end

  ////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
      launch <= 1'b0;
      diagStrobe <= 1'b0;
      driving <= 1'b0;
      busy <= 1'b0;
      readValid <= 1'b0;
    end else begin
      launch <= accept;
      readValid <= 1'b0;
      case (state)
        stIdle: begin
          if (launch) begin
            state <= stStrobe;
            diagStrobe <= 1'b1;
            driving <= kindQ == dkWrite;
            busy <= 1'b1;
          end
        end
        stStrobe: begin
          if (timerDone) begin
            case (kindQ)
              // Data stays on the bus one clock past the strobe
              dkWrite: begin
                state <= stTail;
                diagStrobe <= 1'b0;
              end
              // Sample point reached and the strobe holds one more clock
              dkRead: begin
                state <= stDone;
                readValid <= 1'b1;
              end
              default: begin
                state <= stIdle;
                diagStrobe <= 1'b0;
                busy <= 1'b0;
              end
            endcase
          end
        end
        stTail: begin
          state <= stIdle;
          driving <= 1'b0;
          busy <= 1'b0;
        end
        default: begin
          state <= stIdle;
          diagStrobe <= 1'b0;
          busy <= 1'b0;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Command and bus data
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      kindQ <= cmdKind;
      funcQ <= cmdFunc;
      dataQ <= cmdData;
    end
    if (launch) begin
      ds <= funcQ;
      if (kindQ == dkWrite) begin
        ebusDataOut <= dataQ;
      end
    end
    if (state == stStrobe && timerDone && kindQ == dkRead) begin
      readData <= ebusDataIn;
    end
  end

  // Bus is only driven for an accepted diagnostic write
  assert property (@(posedge clk) disable iff (!arstN)
    $rose(driving) |-> $past(accept, 2) && $past(cmdKind, 2) == dkWrite);

  // Strobe must be down whenever the FSM rests
  assert property (@(posedge clk) disable iff (!arstN)
    state == stIdle |-> !diagStrobe);

endmodule

/* verilog/asciiFieldDecoder.sv */
// Turns a stream of load file characters into 16-bit fields and checks each line checksum
`include "klFe_consts.svh"

module asciiFieldDecoder (
  input  logic       clk,
  input  logic       arstN,
  input  logic       charValid,
  input  logic [6:0] charIn,
  loadLineIf.decoder line,
  output logic       lineGood
);
  import klFePkg::*;

  // Where in the line the next character lands
  typedef enum logic [1:0] {
    psLetter,
    psSpace,
    psField
  } tPos;

  // Record letters
  localparam logic [6:0] charZ = 7'h5A;
  localparam logic [6:0] charT = 7'h54;

  tPos        pos;
  tW16        acc;
  tW16        sum;
  tW16        lineSum;
  logic [7:0] fieldCount;
  logic       endPend;
  logic       isNewline;
  logic       isTerm;

  always_comb begin
    isNewline = charIn == `KLFE_CHAR_NEWLINE;
    isTerm = isNewline || (charIn == `KLFE_CHAR_COMMA);
    // Running sum with the field now closing, checksum included
    lineSum = sum + acc;
  end

  ////////////////////////////////////////
  // Line position, field count, checksum
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pos <= psLetter;
      line.recKind <= rkOther;
      acc <= '0;
      sum <= '0;
      fieldCount <= '0;
      line.fieldStrobe <= 1'b0;
      line.fieldIndex <= '0;
      line.lineEnd <= 1'b0;
      endPend <= 1'b0;
      lineGood <= 1'b0;
    end else begin
      line.fieldStrobe <= 1'b0;
      // Line end trails the checksum strobe by one clock
      line.lineEnd <= endPend;
      endPend <= 1'b0;
      if (charValid) begin
        case (pos)
          psLetter: begin
            pos <= psSpace;
            if (charIn == charZ) begin
              line.recKind <= rkZero;
            end else if (charIn == charT) begin
              line.recKind <= rkText;
            end else begin
              line.recKind <= rkOther;
            end
          end
          // Separator after the letter carries nothing
          psSpace: pos <= psField;
          default: begin
            if (isTerm) begin
              acc <= '0;
              sum <= lineSum;
              line.fieldStrobe <= 1'b1;
              line.fieldIndex <= fieldCount;
              fieldCount <= fieldCount + 8'd1;
              if (isNewline) begin
                // Negated checksum brings the total back to zero
                lineGood <= lineSum == '0;
                sum <= '0;
                fieldCount <= '0;
                endPend <= 1'b1;
                pos <= psLetter;
              end
            end else begin
              // Most significant group comes first
              acc <= {acc[9:0], charIn[5:0] & `KLFE_FIELD_MASK};
            end
          end
        endcase
      end
    end
  end

  // Field value handed over with its strobe
  always_ff @(posedge clk) begin
    if (charValid && pos == psField && isTerm) begin
      line.fieldWord <= acc;
    end
  end

  // Assembler sees the checksum field before it sees the line end
  assert property (@(posedge clk) disable iff (!arstN)
    !(line.fieldStrobe && line.lineEnd));

endmodule

/* verilog/loadWordAssembler.sv */
// Builds PDP-10 memory words, zero ranges and the start address from decoded load line fields
`include "klFe_consts.svh"

module loadWordAssembler (
  input  logic             clk,
  input  logic             arstN,
  loadLineIf.assembler     line,
  output logic             memValid,
  output klFePkg::tMemAddr memAddr,
  output klFePkg::tW36     memWord,
  output logic             zeroValid,
  output klFePkg::tMemAddr zeroAddr,
  output logic [16:0]      zeroCount,
  output logic             startValid,
  output klFePkg::tMemAddr startAddr
);
  import klFePkg::*;

  logic [1:0]  hiAddr;
  logic [13:0] wordsLeft;
  tMemAddr     addr;
  tMemAddr     fieldAddr;
  logic [1:0]  phase;
  tW16         w0;
  tW16         w1;
  logic        isAddr;
  logic        isZero;
  logic        isData;

  always_comb begin
    // High address bits ride in the top of the word count field
    fieldAddr = {hiAddr, line.fieldWord};
    isAddr = line.fieldStrobe && line.fieldIndex == 8'd1;
    isZero = line.fieldStrobe && line.recKind == rkZero && line.fieldIndex == 8'd2;
    // Data fields stop once the counted words are in, so the checksum is skipped
    isData = line.fieldStrobe && line.recKind == rkText && line.fieldIndex >= 8'd2 &&
             wordsLeft != '0;
  end

  ////////////////////////////////////////
  // Address, word count, triple phase
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hiAddr <= '0;
      wordsLeft <= '0;
      addr <= '0;
      phase <= '0;
      memValid <= 1'b0;
      zeroValid <= 1'b0;
      startValid <= 1'b0;
    end else begin
      memValid <= 1'b0;
      zeroValid <= 1'b0;
      startValid <= 1'b0;
      if (line.lineEnd) begin
        phase <= '0;
      end
      if (line.fieldStrobe && line.fieldIndex == 8'd0) begin
        hiAddr <= line.fieldWord[15:14];
        // Scrubbed count of PDP-10 words
        wordsLeft <= line.fieldWord[13:0];
        phase <= '0;
      end
      if (isAddr) begin
        addr <= fieldAddr;
        // T line without words is the transfer line
        if (line.recKind == rkText && wordsLeft == '0) begin
          startValid <= 1'b1;
        end
      end
      if (isZero) begin
        zeroValid <= 1'b1;
      end
      if (isData) begin
        if (phase == 2'd2) begin
          phase <= '0;
          memValid <= 1'b1;
          addr <= addr + 18'd1;
          wordsLeft <= wordsLeft - 14'd1;
        end else begin
          phase <= phase + 2'd1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Output payloads
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (isData) begin
      case (phase)
        2'd0: w0 <= line.fieldWord;
        2'd1: w1 <= line.fieldWord;
        default: begin
          // Bits 0-3 from the third field, then 4-19, then 20-35
          memWord <= {line.fieldWord[3:0], w1, w0};
          memAddr <= addr;
        end
      endcase
    end
    if (isAddr) begin
      startAddr <= fieldAddr;
    end
    if (isZero) begin
      zeroAddr <= addr;
      zeroCount <= (line.fieldWord == '0) ? `KLFE_ZERO_MAX : {1'b0, line.fieldWord};
    end
  end

endmodule

/* verilog/klFrontEnd.sv */
// Front end top level joining the diagnostic bus master and the load line decoder
module klFrontEnd (
  input  logic              clk,
  input  logic              arstN,
  input  logic              charValid,
  input  logic [6:0]        charIn,
  input  logic              cmdValid,
  input  klFePkg::tDiagKind cmdKind,
  input  klFePkg::tDiagFunc cmdFunc,
  input  klFePkg::tW36      cmdData,
  input  klFePkg::tW36      ebusDataIn,
  output klFePkg::tDiagFunc ds,
  output logic              diagStrobe,
  output klFePkg::tW36      ebusDataOut,
  output logic              driving,
  output logic              busy,
  output logic              readValid,
  output klFePkg::tW36      readData,
  output logic              memValid,
  output klFePkg::tMemAddr  memAddr,
  output klFePkg::tW36      memWord,
  output logic              zeroValid,
  output klFePkg::tMemAddr  zeroAddr,
  output logic [16:0]       zeroCount,
  output logic              startValid,
  output klFePkg::tMemAddr  startAddr,
  output logic              lineDone,
  output logic              lineGood
);

  logic       timerLoad;
  logic       timerDone;
  logic [3:0] timerValue;

  ////////////////////////////////////////
  // Diagnostic bus master
  ////////////////////////////////////////

  diagSequencer uSeq (
    .clk, .arstN, .cmdValid, .cmdKind, .cmdFunc, .cmdData, .ebusDataIn, .timerDone,
    .timerLoad, .timerValue, .ds, .diagStrobe, .ebusDataOut, .driving, .busy,
    .readValid, .readData
  );

  strobeTimer uTimer (.clk, .arstN, .timerLoad, .timerValue, .timerDone);

  ////////////////////////////////////////
  // Load line path
  ////////////////////////////////////////

  loadLineIf line ();

  asciiFieldDecoder uDecoder (.clk, .arstN, .charValid, .charIn, .line(line.decoder), .lineGood);

  loadWordAssembler uAssembler (
    .clk, .arstN, .line(line.assembler), .memValid, .memAddr, .memWord, .zeroValid,
    .zeroAddr, .zeroCount, .startValid, .startAddr
  );

  // Line status follows the decoder's end pulse
  assign lineDone = line.lineEnd;

endmodule

/* verification/tbClock.sv */
// Testbench clock and power-on reset source, instantiated once by the testbench top
module tbClock #(
  parameter int periodNs = 20,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset held over the first rising edges
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    // Release on a falling edge, away from the sampling edge
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

/* verification/klFrontEndTb.sv */
// Self-checking testbench for the front end with random bus commands and encoded load lines
`include "klFe_consts.svh"

module klFrontEndTb;
  timeunit 1ns;
  timeprecision 100ps;
  import klFePkg::*;

  localparam int clkPeriod = 20;
  localparam int resetCycles = 10;
  localparam int nWrites = 16;
  localparam int nFuncs = 8;
  localparam int nReads = 16;
  localparam int nTLines = 10;
  // Longest T line is letter and space plus 27 fields of up to 4 chars
  localparam int maxLineChars = 2 + 27 * 4;
  // Each T line also goes out corrupted before two Z lines and a transfer line
  localparam int nLines = 2 * nTLines + 3;
  localparam int nCmds = nWrites + nFuncs + nReads;
  localparam int watchdogCycles = 2 * (resetCycles + nLines * maxLineChars + 20 * nCmds);

  logic        clk;
  logic        arstN;
  logic        charValid;
  logic [6:0]  charIn;
  logic        cmdValid;
  tDiagKind    cmdKind;
  tDiagFunc    cmdFunc;
  tW36         cmdData;
  tW36         ebusDataIn;
  tDiagFunc    ds;
  logic        diagStrobe;
  tW36         ebusDataOut;
  logic        driving;
  logic        busy;
  logic        readValid;
  tW36         readData;
  logic        memValid;
  tMemAddr     memAddr;
  tW36         memWord;
  logic        zeroValid;
  tMemAddr     zeroAddr;
  logic [16:0] zeroCount;
  logic        startValid;
  tMemAddr     startAddr;
  logic        lineDone;
  logic        lineGood;

  // Encoder state for the line being sent
  tW16        fields[$];
  logic [6:0] lineChars[$];
  int         dataPos[$];
  // Expected assembler outputs with the oldest first
  tMemAddr     expMemAddr[$];
  tW36         expMemWord[$];
  tMemAddr     expZeroAddr[$];
  logic [16:0] expZeroCount[$];
  tMemAddr     expStartAddr[$];
  // Corrupted lines carry altered data words
  logic        ignoreMem;

  tbClock #(.periodNs(clkPeriod), .resetCycles(resetCycles)) uClock (.clk, .arstN);

  klFrontEnd DUT (.*);

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////

  task automatic abortRun(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic checkW36(string name, tW36 got, tW36 exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED %0t %s got %09h expected %09h", $time, name, got, exp));
    end
  endtask

  task automatic checkAddr(string name, tMemAddr got, tMemAddr exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED %0t %s got %06o expected %06o", $time, name, got, exp));
    end
  endtask

  task automatic checkFunc(string name, tDiagFunc got, tDiagFunc exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED %0t %s got %03o expected %03o", $time, name, got, exp));
    end
  endtask

  task automatic checkCount(string name, logic [16:0] got, logic [16:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      abortRun($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Random values
  ////////////////////////////////////////

  function automatic tW36 randW36();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[35:0];
  endfunction

  // Always above 64K so the high address bits are exercised
  function automatic tMemAddr randHighAddr();
    return {2'($urandom_range(3, 1)), 16'($urandom())};
  endfunction

  function automatic tDiagFunc randFunc();
    tDiagFunc codes[9];
    codes = '{dfStopClock, dfStartClock, dfStepClock, dfSetReset, dfClrReset,
              dfClrRun, dfContinue, dfParRegReset, dfLoadAr};
    return codes[$urandom_range(8)];
  endfunction

  ////////////////////////////////////////
  // Diagnostic command model
  ////////////////////////////////////////

  // Issues one command and checks every bus signal cycle by cycle after the accept edge
  task automatic runCommand(tDiagKind kind, tDiagFunc func, tW36 data, logic pulseWhileBusy);
    int strobeLen;
    int driveLen;
    int busyLen;
    int readEdge;
    int j;
    tW36 inData;
    strobeLen = (kind == dkWrite) ? `KLFE_WRITE_STROBE :
                (kind == dkRead) ? `KLFE_READ_STROBE : `KLFE_FUNC_STROBE;
    driveLen = (kind == dkWrite) ? `KLFE_WRITE_DRIVE : 0;
    busyLen = (driveLen > strobeLen) ? driveLen : strobeLen;
    // Sample edge counted from the accept edge
    readEdge = 1 + `KLFE_READ_SAMPLE;
    inData = randW36();
    checkBit("busy", busy, 1'b0);
    ebusDataIn = inData;
    cmdValid = 1'b1;
    cmdKind = kind;
    cmdFunc = func;
    cmdData = data;
    @(negedge clk);
    cmdValid = 1'b0;
    for (j = 1; j <= busyLen + 2; j++) begin
      @(negedge clk);
      checkBit("diagStrobe", diagStrobe, j <= strobeLen);
      checkBit("driving", driving, j <= driveLen);
      checkBit("busy", busy, j <= busyLen);
      checkBit("readValid", readValid, kind == dkRead && j == readEdge);
      if (j <= strobeLen) begin
        checkFunc("ds", ds, func);
      end
      if (j <= driveLen) begin
        checkW36("ebusDataOut", ebusDataOut, data);
      end
      if (kind == dkRead && j == readEdge) begin
        checkW36("readData", readData, inData);
      end
      // Stray request in the middle of the strobe
      if (pulseWhileBusy && j == 5) begin
        cmdValid = 1'b1;
        cmdKind = dkWrite;
        cmdFunc = randFunc();
        cmdData = randW36();
      end else begin
        cmdValid = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////
  // Load line encoder
  ////////////////////////////////////////

  // Groups below octal 75 get octal 100 added and the rest go out as is
  function automatic logic [6:0] encodeGroup(logic [5:0] g);
    return (g < 6'o75) ? {1'b1, g} : {1'b0, g};
  endfunction

  // Most significant group first with leading zero groups dropped
  task automatic appendField(tW16 value, logic isData);
    logic [5:0] g;
    logic started;
    int i;
    started = 1'b0;
    for (i = 2; i >= 0; i--) begin
      g = 6'(value >> (6 * i));
      if (g != 6'd0 || started || i == 0) begin
        started = 1'b1;
        if (isData) begin
          dataPos.push_back(lineChars.size());
        end
        lineChars.push_back(encodeGroup(g));
      end
    end
  endtask

  task automatic encodeLine(logic [6:0] letter);
    tW16 sum;
    int i;
    lineChars.delete();
    dataPos.delete();
    sum = '0;
    lineChars.push_back(letter);
    lineChars.push_back(7'h20);
    for (i = 0; i < fields.size(); i++) begin
      appendField(fields[i], i >= 2);
      lineChars.push_back(`KLFE_CHAR_COMMA);
      sum = sum + fields[i];
    end
    // Negated checksum brings the line total to zero
    appendField(-sum, 1'b0);
    lineChars.push_back(`KLFE_CHAR_NEWLINE);
  endtask

  task automatic buildTLine(tMemAddr base, int nWords);
    tW36 w;
    int i;
    fields.delete();
    fields.push_back({base[17:16], 14'(nWords)});
    fields.push_back(base[15:0]);
    for (i = 0; i < nWords; i++) begin
      w = randW36();
      expMemAddr.push_back(base + 18'(i));
      expMemWord.push_back(w);
      // Low half first and top four bits last
      fields.push_back(w[15:0]);
      fields.push_back(w[31:16]);
      fields.push_back({12'h000, w[35:32]});
    end
    encodeLine(7'h54);
  endtask

  task automatic buildZLine(tMemAddr base, tW16 count);
    fields.delete();
    fields.push_back({base[17:16], 14'd1});
    fields.push_back(base[15:0]);
    fields.push_back(count);
    expZeroAddr.push_back(base);
    // Count runs from 1 to 64K so a field of 0 lands on the full 64K
    expZeroCount.push_back({1'b0, count - 16'd1} + 17'd1);
    encodeLine(7'h5A);
  endtask

  // T line without words carries the start address
  task automatic buildStartLine(tMemAddr base);
    fields.delete();
    fields.push_back({base[17:16], 14'd0});
    fields.push_back(base[15:0]);
    expStartAddr.push_back(base);
    encodeLine(7'h54);
  endtask

  // Flips one data bit in a random data character but leaves the checksum
  task automatic corruptLine();
    int pos;
    pos = dataPos[$urandom_range(dataPos.size() - 1)];
    lineChars[pos] = encodeGroup(lineChars[pos][5:0] ^ 6'd1);
  endtask

  task automatic sendLine(logic expGood);
    int i;
    for (i = 0; i < lineChars.size(); i++) begin
      charValid = 1'b1;
      charIn = lineChars[i];
      @(negedge clk);
      // No line end while the line is still coming in
      checkBit("lineDone", lineDone, 1'b0);
    end
    charValid = 1'b0;
    while (!lineDone) begin
      @(negedge clk);
    end
    checkBit("lineGood", lineGood, expGood);
    @(negedge clk);
    // Line end lasts a single clock
    checkBit("lineDone", lineDone, 1'b0);
    if (expMemAddr.size() != 0 || expZeroAddr.size() != 0 || expStartAddr.size() != 0) begin
      abortRun("load line ended with expected assembler outputs never seen");
    end
  endtask

  ////////////////////////////////////////
  // Assembler output monitor
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (arstN) begin
      if (memValid && !ignoreMem) begin
        if (expMemAddr.size() == 0) begin
          abortRun("memory word reported that the encoder never sent");
        end else begin
          checkAddr("memAddr", memAddr, expMemAddr.pop_front());
          checkW36("memWord", memWord, expMemWord.pop_front());
        end
      end
      if (zeroValid) begin
        if (expZeroAddr.size() == 0) begin
          abortRun("zero range reported without a Z line");
        end else begin
          checkAddr("zeroAddr", zeroAddr, expZeroAddr.pop_front());
          checkCount("zeroCount", zeroCount, expZeroCount.pop_front());
        end
      end
      if (startValid) begin
        if (expStartAddr.size() == 0) begin
          abortRun("start address reported without a transfer line");
        end else begin
          checkAddr("startAddr", startAddr, expStartAddr.pop_front());
        end
      end
    end
  end

  // Whole run bounded by its own length
  initial begin
    #(watchdogCycles * clkPeriod);
    abortRun("timeout: DUT stalled");
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int i;
    void'($urandom(32'h7571));
    charValid = 1'b0;
    charIn = '0;
    cmdValid = 1'b0;
    cmdKind = dkWrite;
    cmdFunc = dfStopClock;
    cmdData = '0;
    ebusDataIn = '0;
    ignoreMem = 1'b0;
    @(posedge arstN);
    @(negedge clk);
    // Quiet outputs out of reset
    checkBit("diagStrobe", diagStrobe, 1'b0);
    checkBit("driving", driving, 1'b0);
    checkBit("busy", busy, 1'b0);
    checkBit("readValid", readValid, 1'b0);
    checkBit("memValid", memValid, 1'b0);
    checkBit("zeroValid", zeroValid, 1'b0);
    checkBit("startValid", startValid, 1'b0);
    checkBit("lineDone", lineDone, 1'b0);
    for (i = 0; i < nWrites; i++) begin
      runCommand(dkWrite, randFunc(), randW36(), 1'b0);
    end
    // Functions also get a stray request while busy
    for (i = 0; i < nFuncs; i++) begin
      runCommand(dkFunc, randFunc(), randW36(), 1'b1);
    end
    for (i = 0; i < nReads; i++) begin
      runCommand(dkRead, randFunc(), randW36(), 1'b0);
    end
    for (i = 0; i < nTLines; i++) begin
      buildTLine(randHighAddr(), int'($urandom_range(8, 1)));
      sendLine(1'b1);
      // Same line again with one bad data character
      corruptLine();
      ignoreMem = 1'b1;
      sendLine(1'b0);
      ignoreMem = 1'b0;
    end
    buildZLine(randHighAddr(), 16'h0000);
    sendLine(1'b1);
    buildZLine(randHighAddr(), 16'($urandom_range(65535, 1)));
    sendLine(1'b1);
    buildStartLine(randHighAddr());
    sendLine(1'b1);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* klFrontEnd.f */
+incdir+verilog
verilog/klFePkg.sv
verilog/loadLineIf.sv
verilog/strobeTimer.sv
verilog/diagSequencer.sv
verilog/asciiFieldDecoder.sv
verilog/loadWordAssembler.sv
verilog/klFrontEnd.sv
verification/tbClock.sv
verification/klFrontEndTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module klFrontEndTb -f klFrontEnd.f -o klFrontEndSim
./obj_dir/klFrontEndSim
